//--- dii_package.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug interconnect definitions
// Flit format and the packet type and register subtype codes
// carried in the header of every packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package dii_package;

   // One flit on the interconnect, valid/ready handshake
   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   // Packet type, bits 15:14 of the third flit
   typedef enum logic [1:0] {
      type_reg   = 2'b00,
      type_plain = 2'b01,
      type_event = 2'b10
   } dii_pkt_type;

   // Register subtype, bits 13:10 of the third flit
   // Request codes with other sizes fall between these values
   typedef enum logic [3:0] {
      req_read_16       = 4'b0000,
      req_write_16      = 4'b0100,
      resp_read_ok_16   = 4'b1000,
      resp_read_err_16  = 4'b1100,
      resp_write_ok_16  = 4'b1110,
      resp_write_err_16 = 4'b1111
   } dii_reg_subtype;

endpackage
`default_nettype wire

//--- osd_reg_package.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug module register map
// Addresses of the base and SCM registers, and the request and
// response records passed between the pipeline stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package osd_reg_package;

   // Base registers present in every debug module
   localparam logic [15:0] addr_mod_vendor     = 16'h0000;
   localparam logic [15:0] addr_mod_type       = 16'h0001;
   localparam logic [15:0] addr_mod_version    = 16'h0002;
   localparam logic [15:0] addr_mod_event_dest = 16'h0003;

   // SCM registers, the module specific space starts here
   localparam logic [15:0] addr_sys_vendor  = 16'h0200;
   localparam logic [15:0] addr_sys_device  = 16'h0201;
   localparam logic [15:0] addr_num_mod     = 16'h0202;
   localparam logic [15:0] addr_max_pkt_len = 16'h0203;
   localparam logic [15:0] addr_rst_vector  = 16'h0204;

   // Decoded request kind
   typedef enum logic [1:0] {
      op_read,
      op_write,
      op_bad_size
   } reg_op;

   // Request from the receiver, src is the requester's address
   typedef struct packed {
      reg_op       op;
      logic [15:0] src;
      logic [15:0] addr;
      logic [15:0] wdata;
   } reg_req;

   // Result handed to the transmitter
   typedef struct packed {
      dii_package::dii_reg_subtype subtype;
      logic [15:0]                 dest;
      logic [15:0]                 rdata;
   } reg_resp;

endpackage
`default_nettype wire

//--- dii_pkt_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet receiver
// Collects the header flits of each incoming packet and turns
// register requests for this module into one request record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module dii_pkt_rx (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [15:0]             id,
   input  dii_package::dii_flit    debug_in,
   output logic                    debug_in_ready,
   output osd_reg_package::reg_req req,
   output logic                    req_valid,
   input  logic                    req_ready
);
   import dii_package::*;
   import osd_reg_package::*;

   // Flits seen so far in the current packet, saturates at five
   logic [2:0]  flit_cnt;
   logic        flit_xfer;
   // Latched header words
   logic [15:0] dest_q;
   logic [15:0] src_q;
   logic [15:0] type_q;
   logic [15:0] addr_q;
   logic [15:0] wdata_q;
   // Header words including the flit on the bus right now
   logic [15:0] cur_dest;
   logic [15:0] cur_src;
   logic [15:0] cur_type;
   logic [15:0] cur_addr;
   logic [15:0] cur_wdata;
   logic [3:0]  subtype;
   logic        keep;
   reg_op       op;

   // Stall only while a finished request is still pending
   assign debug_in_ready = ~req_valid | req_ready;
   assign flit_xfer      = debug_in.valid & debug_in_ready;

   always_comb begin
      cur_dest  = dest_q;
      cur_src   = src_q;
      cur_type  = type_q;
      cur_addr  = addr_q;
      cur_wdata = wdata_q;
      case (flit_cnt)
         3'd0: cur_dest = debug_in.data;
         3'd1: cur_src = debug_in.data;
         3'd2: cur_type = debug_in.data;
         3'd3: cur_addr = debug_in.data;
         3'd4: cur_wdata = debug_in.data;
         default: ;
      endcase
   end

   assign subtype = cur_type[13:10];

   always_comb begin
      if (subtype == req_read_16) begin
         op = op_read;
      end else if (subtype == req_write_16) begin
         op = op_write;
      end else begin
         op = op_bad_size;
      end
   end

   // Register request for us with an address, and data for a write
   assign keep = (cur_dest == id) && (cur_type[15:14] == type_reg) &&
                 (flit_cnt >= 3'd3) && ((op != op_write) || (flit_cnt >= 3'd4));

   always_ff @(posedge clk) begin
      if (flit_xfer) begin
         dest_q  <= cur_dest;
         src_q   <= cur_src;
         type_q  <= cur_type;
         addr_q  <= cur_addr;
         wdata_q <= cur_wdata;
      end
      if (flit_xfer && debug_in.last && keep) begin
         req.op    <= op;
         req.src   <= cur_src;
         req.addr  <= cur_addr;
         req.wdata <= cur_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         flit_cnt  <= 3'd0;
         req_valid <= 1'b0;
      end else begin
         if (req_ready) begin
            req_valid <= 1'b0;
         end
         if (flit_xfer) begin
            if (debug_in.last) begin
               flit_cnt <= 3'd0;
               // Anything else is consumed and dropped here
               if (keep) begin
                  req_valid <= 1'b1;
               end
            end else if (flit_cnt != 3'd5) begin
               flit_cnt <= flit_cnt + 3'd1;
            end
         end
      end
   end

endmodule
`default_nettype wire

//--- osd_regaccess.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register access stage
// Serves the base identity registers, hands the module space
// to the SCM and registers one result per request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module osd_regaccess #(
   parameter logic [15:0] MOD_VENDOR  = 16'h0001,
   parameter logic [15:0] MOD_TYPE    = 16'h0001,
   parameter logic [15:0] MOD_VERSION = 16'h0000
) (
   input  logic                     clk,
   input  logic                     rst,
   input  osd_reg_package::reg_req  req,
   input  logic                     req_valid,
   output logic                     req_ready,
   output logic                     scm_request,
   output logic                     scm_write,
   output logic [15:0]              scm_addr,
   output logic [15:0]              scm_wdata,
   input  logic [15:0]              scm_rdata,
   input  logic                     scm_err,
   output osd_reg_package::reg_resp resp,
   output logic                     resp_valid,
   input  logic                     resp_ready
);
   import dii_package::*;
   import osd_reg_package::*;

   logic           req_xfer;
   logic           is_write;
   logic           is_scm;
   logic [15:0]    event_dest;
   logic [15:0]    rdata;
   logic           err;
   dii_reg_subtype subtype;

   // Take a new request when the output slot is free or draining
   assign req_ready = ~resp_valid | resp_ready;
   assign req_xfer  = req_valid & req_ready;
   assign is_write  = req.op == op_write;
   // Module space from 0x0200 up, only for 16-bit accesses
   assign is_scm    = (req.addr >= addr_sys_vendor) && (req.op != op_bad_size);

   assign scm_request = req_xfer & is_scm;
   assign scm_write   = is_write;
   assign scm_addr    = req.addr;
   assign scm_wdata   = req.wdata;

   always_comb begin
      rdata = 16'h0000;
      err   = 1'b0;
      case (req.addr)
         addr_mod_vendor: begin
            rdata = MOD_VENDOR;
            err   = is_write;
         end
         addr_mod_type: begin
            rdata = MOD_TYPE;
            err   = is_write;
         end
         addr_mod_version: begin
            rdata = MOD_VERSION;
            err   = is_write;
         end
         addr_mod_event_dest: rdata = event_dest;
         default: begin
            if (is_scm) begin
               rdata = scm_rdata;
               err   = scm_err;
            end else begin
               err = 1'b1;
            end
         end
      endcase
      if (req.op == op_bad_size) begin
         err = 1'b1;
      end
   end

   // Other sizes are answered as a failed read
   always_comb begin
      case (req.op)
         op_read: subtype = err ? resp_read_err_16 : resp_read_ok_16;
         op_write: subtype = err ? resp_write_err_16 : resp_write_ok_16;
         default: subtype = resp_read_err_16;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         event_dest <= 16'h0000;
         resp_valid <= 1'b0;
      end else begin
         if (req_xfer && is_write && (req.addr == addr_mod_event_dest)) begin
            event_dest <= req.wdata;
         end
         if (req_xfer) begin
            resp_valid <= 1'b1;
         end else if (resp_ready) begin
            resp_valid <= 1'b0;
         end
      end
   end

   // Response goes back to whoever sent the request
   always_ff @(posedge clk) begin
      if (req_xfer) begin
         resp.subtype <= subtype;
         resp.dest    <= req.src;
         resp.rdata   <= rdata;
      end
   end

endmodule
`default_nettype wire

//--- osd_scm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subsystem control register file
// System identity constants and the system and CPU reset vector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module osd_scm #(
   parameter logic [15:0] SYSTEM_VENDOR_ID = 16'h0001,
   parameter logic [15:0] SYSTEM_DEVICE_ID = 16'h0001,
   parameter logic [15:0] NUM_MOD          = 16'h0001,
   parameter logic [15:0] MAX_PKT_LEN      = 16'h0008
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        scm_request,
   input  logic        scm_write,
   input  logic [15:0] scm_addr,
   input  logic [15:0] scm_wdata,
   output logic [15:0] scm_rdata,
   output logic        scm_err,
   output logic [1:0]  rst_vector
);
   import osd_reg_package::*;

   // Read mux, identity values are read-only
   always_comb begin
      scm_rdata = 16'h0000;
      scm_err   = 1'b0;
      case (scm_addr)
         addr_sys_vendor: begin
            scm_rdata = SYSTEM_VENDOR_ID;
            scm_err   = scm_request & scm_write;
         end
         addr_sys_device: begin
            scm_rdata = SYSTEM_DEVICE_ID;
            scm_err   = scm_request & scm_write;
         end
         addr_num_mod: begin
            scm_rdata = NUM_MOD;
            scm_err   = scm_request & scm_write;
         end
         addr_max_pkt_len: begin
            scm_rdata = MAX_PKT_LEN;
            scm_err   = scm_request & scm_write;
         end
         addr_rst_vector: scm_rdata = {14'h0000, rst_vector};
         // Unmapped in the module space
         default: scm_err = scm_request;
      endcase
   end

   // Bit 0 system reset, bit 1 CPU reset
   always_ff @(posedge clk) begin
      if (rst) begin
         rst_vector <= 2'b00;
      end else if (scm_request && scm_write && (scm_addr == addr_rst_vector)) begin
         rst_vector <= scm_wdata[1:0];
      end
   end

endmodule
`default_nettype wire

//--- dii_pkt_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet transmitter
// Holds one register result and sends it as a response packet,
// one flit per accepted handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module dii_pkt_tx (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [15:0]              id,
   input  osd_reg_package::reg_resp resp,
   input  logic                     resp_valid,
   output logic                     resp_ready,
   output dii_package::dii_flit     debug_out,
   input  logic                     debug_out_ready
);
   import dii_package::*;
   import osd_reg_package::*;

   // One state per flit of the packet
   typedef enum logic [2:0] {
      st_idle,
      st_dest,
      st_src,
      st_type,
      st_data
   } tx_state;

   tx_state state;
   reg_resp resp_q;
   logic    has_data;
   logic    flit_xfer;

   // Only idle accepts a new result
   assign resp_ready = state == st_idle;
   // Read data flit only follows a successful read
   assign has_data   = resp_q.subtype == resp_read_ok_16;
   assign flit_xfer  = debug_out.valid & debug_out_ready;

   always_comb begin
      debug_out.valid = state != st_idle;
      debug_out.last  = 1'b0;
      debug_out.data  = 16'h0000;
      case (state)
         st_dest: debug_out.data = resp_q.dest;
         st_src: debug_out.data = id;
         st_type: begin
            debug_out.data = {type_reg, resp_q.subtype, 10'h000};
            debug_out.last = ~has_data;
         end
         st_data: begin
            debug_out.data = resp_q.rdata;
            debug_out.last = 1'b1;
         end
         default: ;
      endcase
   end

   // Advance only when the current flit is taken
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (resp_valid) state <= st_dest;
            st_dest: if (flit_xfer) state <= st_src;
            st_src: if (flit_xfer) state <= st_type;
            st_type: if (flit_xfer) state <= has_data ? st_data : st_idle;
            st_data: if (flit_xfer) state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (resp_valid && resp_ready) begin
         resp_q <= resp;
      end
   end

endmodule
`default_nettype wire

//--- osd_scm_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subsystem control module
// Receive, register access, SCM registers and transmit chained
// on the debug interconnect, plus the system and CPU resets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module osd_scm_subsystem #(
   parameter logic [15:0] SYSTEM_VENDOR_ID = 16'h0001,
   parameter logic [15:0] SYSTEM_DEVICE_ID = 16'h0001,
   parameter logic [15:0] NUM_MOD          = 16'h0001,
   parameter logic [15:0] MAX_PKT_LEN      = 16'h0008,
   parameter logic [15:0] MOD_VENDOR       = 16'h0001,
   parameter logic [15:0] MOD_TYPE         = 16'h0001,
   parameter logic [15:0] MOD_VERSION      = 16'h0000
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [15:0]          id,
   input  dii_package::dii_flit debug_in,
   output logic                 debug_in_ready,
   output dii_package::dii_flit debug_out,
   input  logic                 debug_out_ready,
   output logic                 sys_rst,
   output logic                 cpu_rst
);
   import osd_reg_package::*;

   reg_req      req;
   logic        req_valid;
   logic        req_ready;
   logic        scm_request;
   logic        scm_write;
   logic [15:0] scm_addr;
   logic [15:0] scm_wdata;
   logic [15:0] scm_rdata;
   logic        scm_err;
   reg_resp     resp;
   logic        resp_valid;
   logic        resp_ready;
   logic [1:0]  rst_vector;

   // Software reset bits, forced on during the interconnect reset
   assign sys_rst = rst_vector[0] | rst;
   assign cpu_rst = rst_vector[1] | rst;

   dii_pkt_rx u_pkt_rx (.*);

   osd_regaccess #(
      .MOD_VENDOR  (MOD_VENDOR),
      .MOD_TYPE    (MOD_TYPE),
      .MOD_VERSION (MOD_VERSION)
   ) u_regaccess (.*);

   osd_scm #(
      .SYSTEM_VENDOR_ID (SYSTEM_VENDOR_ID),
      .SYSTEM_DEVICE_ID (SYSTEM_DEVICE_ID),
      .NUM_MOD          (NUM_MOD),
      .MAX_PKT_LEN      (MAX_PKT_LEN)
   ) u_scm (.*);

   dii_pkt_tx u_pkt_tx (.*);

endmodule
`default_nettype wire

//--- osd_scm_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCM subsystem assertions
// Flit handshake stability and reset output rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module osd_scm_asserts (
   input logic                 clk,
   input logic                 rst,
   input dii_package::dii_flit debug_in,
   input logic                 debug_in_ready,
   input dii_package::dii_flit debug_out,
   input logic                 debug_out_ready,
   input logic                 sys_rst,
   input logic                 cpu_rst
);
   timeunit 1ns;
   timeprecision 1ps;

   // A stalled flit holds until it is taken
   assert property (@(posedge clk) disable iff (rst)
      debug_in.valid && !debug_in_ready |=> $stable(debug_in))
      else $error("debug_in changed while stalled");

   assert property (@(posedge clk) disable iff (rst)
      debug_out.valid && !debug_out_ready |=> $stable(debug_out))
      else $error("debug_out changed while stalled");

   // Transmitter idle once reset has been sampled
   assert property (@(posedge clk) rst && $past(rst) |-> !debug_out.valid)
      else $error("debug_out valid during reset");

   assert property (@(posedge clk) rst |-> sys_rst && cpu_rst)
      else $error("reset outputs low during reset");

endmodule

bind osd_scm_subsystem osd_scm_asserts osd_scm_asserts_inst (
   .clk             (clk),
   .rst             (rst),
   .debug_in        (debug_in),
   .debug_in_ready  (debug_in_ready),
   .debug_out       (debug_out),
   .debug_out_ready (debug_out_ready),
   .sys_rst         (sys_rst),
   .cpu_rst         (cpu_rst)
);
`default_nettype wire

//--- tb_osd_scm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCM subsystem testbench
// Random packets from an LFSR, a register model that fills a
// queue of expected response flits, and a watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_osd_scm;
   timeunit 1ns;
   timeprecision 1ps;
   import dii_package::*;
   import osd_reg_package::*;

   localparam int          CLK_PERIOD     = 40;
   localparam int          NUM_PKTS       = 400;
   localparam int          TIMEOUT_CYCLES = NUM_PKTS * 40;
   localparam logic [31:0] SEED           = 32'hcd34_26a8;
   localparam logic [15:0] ID             = 16'h0005;
   localparam logic [15:0] SYS_VENDOR     = 16'h00a1;
   localparam logic [15:0] SYS_DEVICE     = 16'h7e12;
   localparam logic [15:0] NUM_MOD        = 16'h0004;
   localparam logic [15:0] MAX_PKT_LEN    = 16'h0010;
   localparam logic [15:0] MOD_VENDOR     = 16'h0b17;
   localparam logic [15:0] MOD_TYPE       = 16'h0006;
   localparam logic [15:0] MOD_VERSION    = 16'h0002;

   logic        clk = 1'b0;
   logic        rst;
   logic [15:0] id;
   dii_flit     debug_in;
   logic        debug_in_ready;
   dii_flit     debug_out;
   logic        debug_out_ready = 1'b0;
   logic        sys_rst;
   logic        cpu_rst;

   // Separate generators for stimulus and output ready
   logic [31:0] stim_lfsr  = SEED;
   logic [31:0] ready_lfsr = SEED;
   // Expected response flits, {last, data}
   logic [16:0] exp_q[$];
   // Model of the writable registers
   logic [15:0] event_dest_m;
   logic [1:0]  rst_vec_m;
   int          errors     = 0;
   int          resp_count = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   osd_scm_subsystem #(
      .SYSTEM_VENDOR_ID (SYS_VENDOR),
      .SYSTEM_DEVICE_ID (SYS_DEVICE),
      .NUM_MOD          (NUM_MOD),
      .MAX_PKT_LEN      (MAX_PKT_LEN),
      .MOD_VENDOR       (MOD_VENDOR),
      .MOD_TYPE         (MOD_TYPE),
      .MOD_VERSION      (MOD_VERSION)
   ) osd_scm_subsystem_inst (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .sys_rst         (sys_rst),
      .cpu_rst         (cpu_rst)
   );

   // Galois step, taps 32 22 2 1
   function logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
   endfunction

   function logic [15:0] stim_bits(input int n);
      logic [15:0] v;
      v = 16'h0000;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], stim_lfsr[0]};
         stim_lfsr = lfsr_next(stim_lfsr);
      end
      return v;
   endfunction

   function logic ready_bit();
      ready_bit = ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
   endfunction

   // Mapped registers weighted toward the writable ones, then holes
   function logic [15:0] pick_addr(input logic [3:0] sel);
      case (sel)
         4'd0: pick_addr = addr_mod_vendor;
         4'd1: pick_addr = addr_mod_type;
         4'd2: pick_addr = addr_mod_version;
         4'd3, 4'd4: pick_addr = addr_mod_event_dest;
         4'd5: pick_addr = addr_sys_vendor;
         4'd6: pick_addr = addr_sys_device;
         4'd7: pick_addr = addr_num_mod;
         4'd8: pick_addr = addr_max_pkt_len;
         4'd9, 4'd10: pick_addr = addr_rst_vector;
         4'd11: pick_addr = 16'h0004;
         4'd12: pick_addr = 16'h01ff;
         4'd13: pick_addr = 16'h0205;
         4'd14: pick_addr = 16'h1234;
         default: pick_addr = 16'hffff;
      endcase
   endfunction

   task automatic expect_response(input logic [15:0] dest, input dii_reg_subtype sub,
                                  input logic [15:0] rdata);
      exp_q.push_back({1'b0, dest});
      exp_q.push_back({1'b0, ID});
      // Data flit only after a good read
      if (sub == resp_read_ok_16) begin
         exp_q.push_back({1'b0, type_reg, sub, 10'h000});
         exp_q.push_back({1'b1, rdata});
      end else begin
         exp_q.push_back({1'b1, type_reg, sub, 10'h000});
      end
   endtask

   task automatic model_request(input logic [15:0] src, input logic [3:0] code,
                                input logic [15:0] addr, input logic [15:0] wdata);
      logic [15:0] rdata;
      logic        ok;
      rdata = 16'h0000;
      ok    = 1'b1;
      if (code == req_read_16) begin
         case (addr)
            addr_mod_vendor: rdata = MOD_VENDOR;
            addr_mod_type: rdata = MOD_TYPE;
            addr_mod_version: rdata = MOD_VERSION;
            addr_mod_event_dest: rdata = event_dest_m;
            addr_sys_vendor: rdata = SYS_VENDOR;
            addr_sys_device: rdata = SYS_DEVICE;
            addr_num_mod: rdata = NUM_MOD;
            addr_max_pkt_len: rdata = MAX_PKT_LEN;
            addr_rst_vector: rdata = {14'h0000, rst_vec_m};
            default: ok = 1'b0;
         endcase
         expect_response(src, ok ? resp_read_ok_16 : resp_read_err_16, rdata);
      end else if (code == req_write_16) begin
         // Only event_dest and the reset vector take writes
         if (addr == addr_mod_event_dest) begin
            event_dest_m = wdata;
         end else if (addr == addr_rst_vector) begin
            rst_vec_m = wdata[1:0];
         end else begin
            ok = 1'b0;
         end
         expect_response(src, ok ? resp_write_ok_16 : resp_write_err_16, 16'h0000);
      end else begin
         // Other access sizes come back as a failed read
         expect_response(src, resp_read_err_16, 16'h0000);
      end
   endtask

   // Called on a falling edge, returns on the edge after the transfer
   task automatic send_flit(input logic [15:0] data, input logic last);
      debug_in.valid = 1'b1;
      debug_in.last  = last;
      debug_in.data  = data;
      // Ready only moves on the rising edge
      while (!debug_in_ready) @(negedge clk);
      @(negedge clk);
      debug_in.valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   task automatic check_resets();
      assert ({cpu_rst, sys_rst} == rst_vec_m) else begin
         errors++;
         $display("ERR @%0t: reset outputs %b, expected %b", $time,
                  {cpu_rst, sys_rst}, rst_vec_m);
      end
   endtask

   task automatic send_packet();
      logic [15:0] dest;
      logic [15:0] src;
      logic [15:0] addr;
      logic [15:0] wdata;
      logic [15:0] word;
      logic [15:0] r;
      logic [1:0]  ptype;
      logic [3:0]  code;
      logic        for_us;
      int          len;
      r    = stim_bits(2);
      dest = (r == 16'd0) ? ID + 16'd1 + stim_bits(3) : ID;
      r    = stim_bits(3);
      case (r[2:0])
         3'd6: ptype = type_plain;
         3'd7: ptype = type_event;
         default: ptype = type_reg;
      endcase
      r = stim_bits(3);
      if (r[2:0] < 3'd3) begin
         code = req_read_16;
      end else if (r[2:0] < 3'd6) begin
         code = req_write_16;
      end else begin
         r = stim_bits(2);
         case (r[1:0])
            2'd0: code = 4'b0001;
            2'd1: code = 4'b0010;
            2'd2: code = 4'b0101;
            default: code = 4'b0110;
         endcase
      end
      r     = stim_bits(4);
      addr  = pick_addr(r[3:0]);
      src   = stim_bits(16);
      wdata = stim_bits(16);
      // Writes carry a data flit, sometimes trailing filler too
      len = (code == req_write_16) ? 5 : 4;
      r   = stim_bits(2);
      if (r == 16'd3) len = len + 2;
      for_us = (dest == ID) && (ptype == type_reg);
      if (for_us) model_request(src, code, addr, wdata);
      for (int i = 0; i < len; i++) begin
         case (i)
            0: word = dest;
            1: word = src;
            2: word = {ptype, code, 10'h000};
            3: word = addr;
            4: word = wdata;
            default: word = stim_bits(16);
         endcase
         send_flit(word, i == len - 1);
         r = stim_bits(2);
         if (r == 16'd0) begin
            r = stim_bits(3);
            repeat (r) @(negedge clk);
         end
      end
      // Reset outputs follow a reset vector write
      if (for_us && (code == req_write_16) && (addr == addr_rst_vector)) begin
         wait_drain();
         check_resets();
      end
   endtask

   // Compare one accepted output flit with the head of the queue
   task automatic check_flit(input logic last, input logic [15:0] data);
      logic [16:0] want;
      assert (exp_q.size() != 0) else begin
         errors++;
         $display("ERR @%0t: flit %h with no response pending", $time, data);
      end
      if (exp_q.size() != 0) begin
         want = exp_q.pop_front();
         assert ({last, data} == want) else begin
            errors++;
            $display("ERR @%0t: flit last=%b data=%h, expected last=%b data=%h",
                     $time, last, data, want[16], want[15:0]);
         end
         if (last) resp_count++;
      end
   endtask

   // Output side, ready high three times in four
   initial begin
      logic b0;
      logic b1;
      forever begin
         @(negedge clk);
         b0 = ready_bit();
         b1 = ready_bit();
         debug_out_ready = b0 | b1;
         if (debug_out.valid && debug_out_ready) begin
            check_flit(debug_out.last, debug_out.data);
         end
      end
   end

   initial begin
      rst          = 1'b1;
      id           = ID;
      debug_in     = '0;
      event_dest_m = 16'h0000;
      rst_vec_m    = 2'b00;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_resets();
      assert (debug_in_ready) else begin
         errors++;
         $display("ERR @%0t: debug_in_ready low after reset", $time);
      end
      for (int n = 0; n < NUM_PKTS; n++) send_packet();
      wait_drain();
      // Window for stray responses
      repeat (40) @(negedge clk);
      check_resets();
      $display("Run complete: %0d responses checked, %0d errors", resp_count, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule
`default_nettype wire

//--- tb.f
dii_package.sv
osd_reg_package.sv
dii_pkt_rx.sv
osd_regaccess.sv
osd_scm.sv
dii_pkt_tx.sv
osd_scm_subsystem.sv
osd_scm_asserts.sv
tb_osd_scm.sv

//--- Makefile
# Verilator build and run of the SCM subsystem testbench

SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_osd_scm: $(SRCS) tb.f
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_osd_scm -f tb.f -Mdir obj_dir

run: obj_dir/Vtb_osd_scm
	@out="$$(./obj_dir/Vtb_osd_scm)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
